// File: logic/edram_map_pkg.sv
package edram_map_pkg;

    // core port widths
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

    // bank population
    localparam int unsigned NB_BANKS       = 16;
    localparam int unsigned BANK_IDX_WIDTH = $clog2(NB_BANKS);

    // address map: sixteen equal banks placed back to back from the base
    localparam logic [ADDR_WIDTH-1:0] EDRAM_BASE = 32'h1000_0000;
    localparam logic [ADDR_WIDTH-1:0] BANK_SIZE  = 32'h0001_0000;

    // local word offset inside one bank
    localparam int unsigned BANK_OFFSET_WIDTH = $clog2(BANK_SIZE);

    typedef enum logic [BANK_IDX_WIDTH-1:0] {
        EDRAM_0,
        EDRAM_1,
        EDRAM_2,
        EDRAM_3,
        EDRAM_4,
        EDRAM_5,
        EDRAM_6,
        EDRAM_7,
        EDRAM_8,
        EDRAM_9,
        EDRAM_10,
        EDRAM_11,
        EDRAM_12,
        EDRAM_13,
        EDRAM_14,
        EDRAM_15
    } edram_bank_e;

    // first address of bank k, the range ends at the next bank's base
    function automatic logic [ADDR_WIDTH-1:0] bank_base(input int unsigned k);
        logic [ADDR_WIDTH-1:0] k_ext;
        k_ext = ADDR_WIDTH'(k);
        return EDRAM_BASE + k_ext * BANK_SIZE;
    endfunction

endpackage

// File: logic/edram_addr_decode.sv
`timescale 1ns/1ps

module edram_addr_decode
    import edram_map_pkg::*;
(
    input  logic [ADDR_WIDTH-1:0]        addr_i,
    output edram_bank_e                  bank_idx_o,
    output logic                         hit_o,
    output logic [BANK_OFFSET_WIDTH-1:0] offset_o
);

    // one match flag per bank range
    logic [NB_BANKS-1:0]   bank_match;
    // address relative to the selected bank base
    logic [ADDR_WIDTH-1:0] local_addr;

    // start inclusive, end exclusive
    for (genvar k = 0; k < NB_BANKS; k++) begin : gen_range
        assign bank_match[k] = (addr_i >= bank_base(k)) &&
                               (addr_i < bank_base(k) + BANK_SIZE);
    end

    // ranges are disjoint, so at most one flag is set
    always_comb begin
        bank_idx_o = EDRAM_0;
        hit_o      = 1'b0;
        for (int k = 0; k < NB_BANKS; k++) begin
            if (bank_match[k]) begin
                bank_idx_o = edram_bank_e'(BANK_IDX_WIDTH'(k));
                hit_o      = 1'b1;
            end
        end
    end

    // strip the bank base so each bank sees a zero based offset
    assign local_addr = addr_i - bank_base(bank_idx_o);

    // a miss has no meaningful offset
    assign offset_o = hit_o ? local_addr[BANK_OFFSET_WIDTH-1:0] : '0;

endmodule

// File: logic/edram_req_steer.sv
`timescale 1ns/1ps

module edram_req_steer
    import edram_map_pkg::*;
(
    input  logic                                        req_i,
    input  logic                                        we_i,
    input  logic [BE_WIDTH-1:0]                         be_i,
    input  logic [DATA_WIDTH-1:0]                       wdata_i,
    input  edram_bank_e                                 bank_idx_i,
    input  logic                                        hit_i,
    input  logic [BANK_OFFSET_WIDTH-1:0]                offset_i,
    output logic [NB_BANKS-1:0]                         bank_req_o,
    output logic [NB_BANKS-1:0]                         bank_we_o,
    output logic [NB_BANKS-1:0][BANK_OFFSET_WIDTH-1:0]  bank_addr_o,
    output logic [NB_BANKS-1:0][BE_WIDTH-1:0]           bank_be_o,
    output logic [NB_BANKS-1:0][DATA_WIDTH-1:0]         bank_wdata_o
);

    // one-hot bank select, all low on a miss or without a request
    logic [NB_BANKS-1:0] bank_sel;

    for (genvar k = 0; k < NB_BANKS; k++) begin : gen_bank
        assign bank_sel[k] = req_i && hit_i &&
                             (bank_idx_i == edram_bank_e'(BANK_IDX_WIDTH'(k)));

        assign bank_req_o[k] = bank_sel[k];
        assign bank_we_o[k]  = bank_sel[k] && we_i;

        // idle banks see all zeros
        assign bank_addr_o[k]  = bank_sel[k] ? offset_i : '0;
        // full byte-enable vector goes through unchanged
        assign bank_be_o[k]    = bank_sel[k] ? be_i : '0;
        assign bank_wdata_o[k] = bank_sel[k] ? wdata_i : '0;
    end

endmodule

// File: logic/edram_rdata_select.sv
`timescale 1ns/1ps

module edram_rdata_select
    import edram_map_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic                                hit_i,
    input  edram_bank_e                         bank_idx_i,
    input  logic [NB_BANKS-1:0][DATA_WIDTH-1:0] bank_rdata_i,
    output logic [DATA_WIDTH-1:0]               rdata_o
);

    // a read that lands in a bank
    logic        rd_issue;
    // bank whose data returns in the current cycle
    edram_bank_e rd_idx_q;
    logic        rd_valid_q;

    assign rd_issue = req_i && !we_i && hit_i;

    // valid flag for the returning read, one cycle behind the request
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_issue;
        end
    end

    // remember which bank was read, the live address may already point elsewhere
    always_ff @(posedge clk_i) begin
        if (rd_issue) begin
            rd_idx_q <= bank_idx_i;
        end
    end

    // writes, misses and idle cycles return zero
    assign rdata_o = rd_valid_q ? bank_rdata_i[rd_idx_q] : '0;

endmodule

// File: logic/cim_edram_demux.sv
`timescale 1ns/1ps

module cim_edram_demux
    import edram_map_pkg::*;
(
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,

    // core memory port
    input  logic                                        core_req_i,
    input  logic                                        core_we_i,
    input  logic [ADDR_WIDTH-1:0]                       core_addr_i,
    input  logic [BE_WIDTH-1:0]                         core_be_i,
    input  logic [DATA_WIDTH-1:0]                       core_wdata_i,
    output logic [DATA_WIDTH-1:0]                       core_rdata_o,

    // eDRAM bank ports, indexed by bank number
    output logic [NB_BANKS-1:0]                         bank_req_o,
    output logic [NB_BANKS-1:0]                         bank_we_o,
    output logic [NB_BANKS-1:0][BANK_OFFSET_WIDTH-1:0]  bank_addr_o,
    output logic [NB_BANKS-1:0][BE_WIDTH-1:0]           bank_be_o,
    output logic [NB_BANKS-1:0][DATA_WIDTH-1:0]         bank_wdata_o,
    input  logic [NB_BANKS-1:0][DATA_WIDTH-1:0]         bank_rdata_i
);

    // decode results shared by the request and return paths
    edram_bank_e                  dec_bank_idx;
    logic                         dec_hit;
    logic [BANK_OFFSET_WIDTH-1:0] dec_offset;

    edram_addr_decode i_addr_decode (
        .addr_i     (core_addr_i),
        .bank_idx_o (dec_bank_idx),
        .hit_o      (dec_hit),
        .offset_o   (dec_offset)
    );

    // request path is purely combinational
    edram_req_steer i_req_steer (
        .req_i        (core_req_i),
        .we_i         (core_we_i),
        .be_i         (core_be_i),
        .wdata_i      (core_wdata_i),
        .bank_idx_i   (dec_bank_idx),
        .hit_i        (dec_hit),
        .offset_i     (dec_offset),
        .bank_req_o   (bank_req_o),
        .bank_we_o    (bank_we_o),
        .bank_addr_o  (bank_addr_o),
        .bank_be_o    (bank_be_o),
        .bank_wdata_o (bank_wdata_o)
    );

    // read data follows the request by one cycle
    edram_rdata_select i_rdata_select (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (core_req_i),
        .we_i         (core_we_i),
        .hit_i        (dec_hit),
        .bank_idx_i   (dec_bank_idx),
        .bank_rdata_i (bank_rdata_i),
        .rdata_o      (core_rdata_o)
    );

endmodule

// File: test/edram_demux_assertions.sv
`timescale 1ns/1ps

module edram_demux_assertions
    import edram_map_pkg::*;
(
    input logic                  clk_i,
    input logic                  rst_n_i,
    input logic                  core_req_i,
    input logic                  core_we_i,
    input logic                  hit_i,
    input logic [NB_BANKS-1:0]   bank_req_o,
    input logic [DATA_WIDTH-1:0] core_rdata_o
);

    // ranges are disjoint so only one bank may be addressed
    bank_req_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(bank_req_o))
        else $error("more than one bank request is high: %b", bank_req_o);

    bank_req_needs_core_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|bank_req_o) |-> core_req_i)
        else $error("a bank request is high without a core request");

    // a read outside the map returns zero in the next cycle
    read_miss_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (core_req_i && !core_we_i && !hit_i) |=> (core_rdata_o == '0))
        else $error("read miss returned nonzero data %h", core_rdata_o);

endmodule

// File: test/edram_checker.sv
`timescale 1ns/1ps

module edram_checker
    import edram_map_pkg::*;
#(
    parameter logic [7:0] DATA_TAG = 8'hc3
) (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    input  logic [8*16-1:0]                            name_i,
    input  int                                         exp_bank_i,
    input  logic                                       core_req_i,
    input  logic                                       core_we_i,
    input  logic [ADDR_WIDTH-1:0]                      core_addr_i,
    input  logic [BE_WIDTH-1:0]                        core_be_i,
    input  logic [DATA_WIDTH-1:0]                      core_wdata_i,
    input  logic [DATA_WIDTH-1:0]                      core_rdata_o,
    input  logic [NB_BANKS-1:0]                        bank_req_o,
    input  logic [NB_BANKS-1:0]                        bank_we_o,
    input  logic [NB_BANKS-1:0][BANK_OFFSET_WIDTH-1:0] bank_addr_o,
    input  logic [NB_BANKS-1:0][BE_WIDTH-1:0]          bank_be_o,
    input  logic [NB_BANKS-1:0][DATA_WIDTH-1:0]        bank_wdata_o,
    output int                                         check_count_o,
    output int                                         error_count_o
);

    // expected selected bank this cycle, -1 for none
    int              sel;
    logic            sel_j;
    // read issued in the previous cycle
    logic            prev_rd;
    int              prev_bank;
    logic [15:0]     prev_off;
    logic [8*16-1:0] prev_name;
    logic [31:0]     exp_rdata;

    function automatic logic in_edram_range(input logic [ADDR_WIDTH-1:0] addr);
        return (addr >= EDRAM_BASE) && ((addr - EDRAM_BASE) < NB_BANKS * BANK_SIZE);
    endfunction

    function automatic int bank_of(input logic [ADDR_WIDTH-1:0] addr);
        return int'((addr - EDRAM_BASE) / BANK_SIZE);
    endfunction

    function automatic logic [15:0] offset_of(input logic [ADDR_WIDTH-1:0] addr);
        return 16'((addr - EDRAM_BASE) % BANK_SIZE);
    endfunction

    // bank number on top, tag byte, then the offset that was read
    function automatic logic [31:0] bank_word(input int k, input logic [15:0] off);
        return {8'(k), DATA_TAG, off};
    endfunction

    task automatic check_value(input logic [8*16-1:0] name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        check_count_o++;
        if (act !== exp) begin
            error_count_o++;
            $display("FAILED %0s %0s: expected %h, actual %h", name, what, exp, act);
        end
    endtask

    initial begin
        check_count_o = 0;
        error_count_o = 0;
        prev_rd       = 1'b0;
        prev_bank     = 0;
        prev_off      = '0;
        prev_name     = "reset";
    end

    // inputs move just after the rising edge, so the falling edge sees them settled
    always @(negedge clk_i) begin
        if (!core_req_i) begin
            sel = -1;
        end else if (exp_bank_i >= -1) begin
            sel = exp_bank_i;
        end else if (in_edram_range(core_addr_i)) begin
            sel = bank_of(core_addr_i);
        end else begin
            sel = -1;
        end

        for (int j = 0; j < NB_BANKS; j++) begin
            sel_j = (j == sel);
            check_value(name_i, $sformatf("bank %0d req", j), 32'(sel_j), 32'(bank_req_o[j]));
            check_value(name_i, $sformatf("bank %0d we", j), 32'(sel_j && core_we_i),
                        32'(bank_we_o[j]));
            check_value(name_i, $sformatf("bank %0d addr", j),
                        sel_j ? 32'(offset_of(core_addr_i)) : 32'h0, 32'(bank_addr_o[j]));
            check_value(name_i, $sformatf("bank %0d be", j),
                        sel_j ? 32'(core_be_i) : 32'h0, 32'(bank_be_o[j]));
            check_value(name_i, $sformatf("bank %0d wdata", j),
                        sel_j ? core_wdata_i : 32'h0, bank_wdata_o[j]);
        end

        // read data belongs to the previous cycle's request
        if (rst_n_i) begin
            exp_rdata = prev_rd ? bank_word(prev_bank, prev_off) : 32'h0;
            check_value(prev_name, "core rdata", exp_rdata, core_rdata_o);
        end

        prev_rd   = rst_n_i && (sel >= 0) && !core_we_i;
        prev_bank = sel;
        prev_off  = offset_of(core_addr_i);
        prev_name = name_i;
    end

endmodule

// File: test/cim_edram_demux_tb.sv
`timescale 1ns/1ps

module cim_edram_demux_tb
    import edram_map_pkg::*;
;

    localparam int unsigned CLK_PERIOD    = 20;
    localparam int unsigned RESET_CYCLES  = 16;
    localparam int unsigned N_DIRECTED    = 15;
    localparam int unsigned N_RANDOM      = 24;
    localparam int unsigned N_ENTRIES     = N_DIRECTED + N_RANDOM;
    localparam int unsigned MARGIN_CYCLES = 20;
    // middle byte of every word a bank returns
    localparam logic [7:0]  DATA_TAG      = 8'hc3;

    // starts low without a falling edge at time zero
    logic                                       clk_i = 1'b0;
    logic                                       rst_n_i;
    logic                                       core_req_i;
    logic                                       core_we_i;
    logic [ADDR_WIDTH-1:0]                      core_addr_i;
    logic [BE_WIDTH-1:0]                        core_be_i;
    logic [DATA_WIDTH-1:0]                      core_wdata_i;
    logic [DATA_WIDTH-1:0]                      core_rdata_o;
    logic [NB_BANKS-1:0]                        bank_req_o;
    logic [NB_BANKS-1:0]                        bank_we_o;
    logic [NB_BANKS-1:0][BANK_OFFSET_WIDTH-1:0] bank_addr_o;
    logic [NB_BANKS-1:0][BE_WIDTH-1:0]          bank_be_o;
    logic [NB_BANKS-1:0][DATA_WIDTH-1:0]        bank_wdata_o;
    logic [NB_BANKS-1:0][DATA_WIDTH-1:0]        bank_rdata_i;

    // entry currently on the core port as seen by the checker
    logic [8*16-1:0]       cur_name;
    int                    cur_exp_bank;
    int                    check_count;
    int                    error_count;
    integer                seed;

    // stimulus table with exp bank -1 for no request and -2 when taken from the map
    logic [8*16-1:0]       tab_name  [N_ENTRIES];
    logic                  tab_req   [N_ENTRIES];
    logic                  tab_we    [N_ENTRIES];
    logic [ADDR_WIDTH-1:0] tab_addr  [N_ENTRIES];
    logic [BE_WIDTH-1:0]   tab_be    [N_ENTRIES];
    logic [DATA_WIDTH-1:0] tab_wdata [N_ENTRIES];
    int                    tab_bank  [N_ENTRIES];
    int                    n_entries;

    cim_edram_demux DUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .core_req_i   (core_req_i),
        .core_we_i    (core_we_i),
        .core_addr_i  (core_addr_i),
        .core_be_i    (core_be_i),
        .core_wdata_i (core_wdata_i),
        .core_rdata_o (core_rdata_o),
        .bank_req_o   (bank_req_o),
        .bank_we_o    (bank_we_o),
        .bank_addr_o  (bank_addr_o),
        .bank_be_o    (bank_be_o),
        .bank_wdata_o (bank_wdata_o),
        .bank_rdata_i (bank_rdata_i)
    );

    edram_checker #(
        .DATA_TAG (DATA_TAG)
    ) u_checker (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .name_i        (cur_name),
        .exp_bank_i    (cur_exp_bank),
        .core_req_i    (core_req_i),
        .core_we_i     (core_we_i),
        .core_addr_i   (core_addr_i),
        .core_be_i     (core_be_i),
        .core_wdata_i  (core_wdata_i),
        .core_rdata_o  (core_rdata_o),
        .bank_req_o    (bank_req_o),
        .bank_we_o     (bank_we_o),
        .bank_addr_o   (bank_addr_o),
        .bank_be_o     (bank_be_o),
        .bank_wdata_o  (bank_wdata_o),
        .check_count_o (check_count),
        .error_count_o (error_count)
    );

    bind cim_edram_demux edram_demux_assertions u_assertions (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .core_req_i   (core_req_i),
        .core_we_i    (core_we_i),
        .hit_i        (dec_hit),
        .bank_req_o   (bank_req_o),
        .core_rdata_o (core_rdata_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // bank models return their word one cycle after a read and junk otherwise
    always @(posedge clk_i) begin
        for (int k = 0; k < NB_BANKS; k++) begin
            if (bank_req_o[k] && !bank_we_o[k]) begin
                bank_rdata_i[k] <= {8'(k), DATA_TAG, 16'(bank_addr_o[k])};
            end else begin
                bank_rdata_i[k] <= {8'hee, 8'(k), 16'hbad0};
            end
        end
    end

    task automatic add_entry(input logic [8*16-1:0] name, input logic req, input logic we,
                             input logic [ADDR_WIDTH-1:0] addr, input logic [BE_WIDTH-1:0] be,
                             input logic [DATA_WIDTH-1:0] wdata, input int exp_bank);
        tab_name[n_entries]  = name;
        tab_req[n_entries]   = req;
        tab_we[n_entries]    = we;
        tab_addr[n_entries]  = addr;
        tab_be[n_entries]    = be;
        tab_wdata[n_entries] = wdata;
        tab_bank[n_entries]  = exp_bank;
        n_entries++;
    endtask

    task automatic build_table();
        logic [ADDR_WIDTH-1:0] r_addr;
        logic [31:0]           r_ctl;
        n_entries = 0;
        add_entry("idle_after_reset", 1'b0, 1'b0, 32'h1002_0000, 4'h0, 32'h0, -1);
        add_entry("wr_bank0_base", 1'b1, 1'b1, 32'h1000_0000, 4'hf, 32'h0123_4567, 0);
        add_entry("wr_bank5_mid", 1'b1, 1'b1, 32'h1005_1234, 4'h3, 32'ha5a5_5a5a, 5);
        add_entry("wr_bank15_last", 1'b1, 1'b1, 32'h100f_fffc, 4'hc, 32'hdead_beef, 15);
        add_entry("rd_bank3", 1'b1, 1'b0, 32'h1003_0040, 4'hf, 32'h0, 3);
        add_entry("rd_bank7", 1'b1, 1'b0, 32'h1007_0100, 4'hf, 32'h0, 7);
        add_entry("rd_bank12", 1'b1, 1'b0, 32'h100c_abc0, 4'hf, 32'h0, 12);
        add_entry("rd_bank0_b2b", 1'b1, 1'b0, 32'h1000_0004, 4'hf, 32'h0, 0);
        add_entry("rd_miss_low", 1'b1, 1'b0, 32'h0fff_fffc, 4'hf, 32'h0, -1);
        add_entry("rd_bank1_after", 1'b1, 1'b0, 32'h1001_0008, 4'hf, 32'h0, 1);
        add_entry("wr_miss_high", 1'b1, 1'b1, 32'h1010_0000, 4'hf, 32'h1111_2222, -1);
        add_entry("rd_miss_high", 1'b1, 1'b0, 32'h2000_0000, 4'hf, 32'h0, -1);
        add_entry("idle_addr_bank9", 1'b0, 1'b0, 32'h1009_0000, 4'hf, 32'h3333_4444, -1);
        add_entry("wr_then_rd_bank4", 1'b1, 1'b1, 32'h1004_0010, 4'h5, 32'h5555_6666, 4);
        add_entry("rd_bank4", 1'b1, 1'b0, 32'h1004_0010, 4'hf, 32'h0, 4);
        // random block covers a little below the base up past the last bank
        for (int i = 0; i < N_RANDOM; i++) begin
            r_addr = 32'h0fff_0000 + ($unsigned($random(seed)) % 32'h0012_0000);
            r_addr[1:0] = 2'b00;
            r_ctl = $random(seed);
            add_entry("random", r_ctl[3:0] != 4'h0, r_ctl[4], r_addr, r_ctl[11:8],
                      $random(seed), -2);
        end
    endtask

    task automatic apply_entry(input int i);
        core_req_i   = tab_req[i];
        core_we_i    = tab_we[i];
        core_addr_i  = tab_addr[i];
        core_be_i    = tab_be[i];
        core_wdata_i = tab_wdata[i];
        cur_name     = tab_name[i];
        cur_exp_bank = tab_bank[i];
    endtask

    initial begin
        seed         = 32'hae3f_4ba3;
        rst_n_i      = 1'b0;
        core_req_i   = 1'b0;
        core_we_i    = 1'b0;
        core_addr_i  = '0;
        core_be_i    = '0;
        core_wdata_i = '0;
        bank_rdata_i = '0;
        cur_name     = "reset";
        cur_exp_bank = -1;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        for (int i = 0; i < n_entries; i++) begin
            @(posedge clk_i);
            #1;
            apply_entry(i);
        end
        // idle cycles so the last read comes back and is checked
        @(posedge clk_i);
        #1;
        core_req_i   = 1'b0;
        cur_name     = "drain";
        cur_exp_bank = -1;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        #1;
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + N_ENTRIES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the stimulus table did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: verilog.f
logic/edram_map_pkg.sv
logic/edram_addr_decode.sv
logic/edram_req_steer.sv
logic/edram_rdata_select.sv
logic/cim_edram_demux.sv
test/edram_demux_assertions.sv
test/edram_checker.sv
test/cim_edram_demux_tb.sv

// File: Bender.yml
package:
  name: cim_edram_demux

sources:
  # synthesizable demux, package first
  - files:
      - logic/edram_map_pkg.sv
      - logic/edram_addr_decode.sv
      - logic/edram_req_steer.sv
      - logic/edram_rdata_select.sv
      - logic/cim_edram_demux.sv

  # simulation only
  - target: test
    files:
      - test/edram_demux_assertions.sv
      - test/edram_checker.sv
      - test/cim_edram_demux_tb.sv
